//--- common/fft_pkg.sv
`default_nettype none

package fft_pkg;

   localparam int FFT_N      = 16;
   localparam int FFT_LOG2N  = $clog2(FFT_N);
   localparam int FFT_STAGES = FFT_LOG2N / 2;   // radix-2^2 stages.
   localparam int SAMPLE_W   = 16;              // room for 16x growth of +-511.
   localparam int TW_W       = 16;
   localparam int TW_FRAC    = 14;              // q1.14 coefficients.

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [FFT_LOG2N-1:0]       idx_t;
   typedef logic signed [TW_W-1:0]     twiddle_t;

   // cos(2*pi*k/16), rounded.
   localparam twiddle_t TW_RE [FFT_N] = '{
       16'sd16384,
       16'sd15137,
       16'sd11585,
       16'sd6270,
       16'sd0,
      -16'sd6270,
      -16'sd11585,
      -16'sd15137,
      -16'sd16384,
      -16'sd15137,
      -16'sd11585,
      -16'sd6270,
       16'sd0,
       16'sd6270,
       16'sd11585,
       16'sd15137
   };

   // -sin(2*pi*k/16), rounded.
   localparam twiddle_t TW_IM [FFT_N] = '{
       16'sd0,
      -16'sd6270,
      -16'sd11585,
      -16'sd15137,
      -16'sd16384,
      -16'sd15137,
      -16'sd11585,
      -16'sd6270,
       16'sd0,
       16'sd6270,
       16'sd11585,
       16'sd15137,
       16'sd16384,
       16'sd15137,
       16'sd11585,
       16'sd6270
   };

endpackage

`default_nettype wire

//--- common/fft_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// one complex sample per valid cycle, no back-pressure.
interface fft_stream_if
   import fft_pkg::*;
();

   logic    valid;
   sample_t re;
   sample_t im;
   idx_t    ctr;   // position in frame at this point.

   modport src (
      output valid,
      output re,
      output im,
      output ctr
   );

   modport dst (
      input valid,
      input re,
      input im,
      input ctr
   );

endinterface

`default_nettype wire

//--- fft_stage/fft_bfi.sv
`timescale 1ns/1ps
`default_nettype none

module fft_bfi
   import fft_pkg::*;
#(
   parameter int STAGE = 0
) (
   input  logic      clk,
   input  logic      reset_i,
   input  logic      sel_i,
   fft_stream_if.dst in_s,
   fft_stream_if.src out_s
);

   localparam int   DLY      = 2 ** (2 * (FFT_STAGES - STAGE) - 1);
   localparam idx_t FILL_MAX = idx_t'(DLY);

   sample_t dl_re [DLY];
   sample_t dl_im [DLY];
   sample_t res_re;
   sample_t res_im;
   sample_t push_re;
   sample_t push_im;
   idx_t    fill_cnt;
   logic    full;

   assign full = (fill_cnt == FILL_MAX);

   always_comb begin
      if (sel_i) begin
         res_re  = dl_re[DLY-1] + in_s.re;   // upper half.
         res_im  = dl_im[DLY-1] + in_s.im;
         push_re = dl_re[DLY-1] - in_s.re;   // lower half, out next pass.
         push_im = dl_im[DLY-1] - in_s.im;
      end else begin
         res_re  = dl_re[DLY-1];
         res_im  = dl_im[DLY-1];
         push_re = in_s.re;
         push_im = in_s.im;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         fill_cnt    <= '0;
         out_s.valid <= 1'b0;
         for (int i = 0; i < DLY; i++) begin
            dl_re[i] <= '0;
            dl_im[i] <= '0;
         end
      end else begin
         out_s.valid <= in_s.valid && full;
         if (in_s.valid) begin
            if (!full) begin
               fill_cnt <= fill_cnt + idx_t'(1);
            end
            for (int i = DLY - 1; i > 0; i--) begin
               dl_re[i] <= dl_re[i-1];
               dl_im[i] <= dl_im[i-1];
            end
            dl_re[0] <= push_re;
            dl_im[0] <= push_im;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_s.valid) begin
         out_s.re  <= res_re;
         out_s.im  <= res_im;
         out_s.ctr <= in_s.ctr - FILL_MAX;   // result lags input by DLY.
      end
   end

   // line fills with the first half block of a frame.
   assert property (@(posedge clk) disable iff (reset_i)
      $rose(full) |-> ($past(in_s.ctr) == FILL_MAX - idx_t'(1)))
      else $error("bfi delay line filled out of step with frame");

   // upstream counter must start a frame at position 0.
   assert property (@(posedge clk) disable iff (reset_i)
      (in_s.valid && !full) |-> !sel_i)
      else $error("bfi select high while delay line filling");

endmodule

`default_nettype wire

//--- fft_stage/fft_bfii.sv
`timescale 1ns/1ps
`default_nettype none

module fft_bfii
   import fft_pkg::*;
#(
   parameter int STAGE = 0
) (
   input  logic      clk,
   input  logic      reset_i,
   input  logic      sel_i,
   input  logic      tsel_i,
   fft_stream_if.dst in_s,
   fft_stream_if.src out_s
);

   localparam int   DLY      = 2 ** (2 * (FFT_STAGES - STAGE) - 2);
   localparam idx_t FILL_MAX = idx_t'(DLY);

   sample_t dl_re [DLY];
   sample_t dl_im [DLY];
   sample_t x_re;
   sample_t x_im;
   sample_t res_re;
   sample_t res_im;
   sample_t push_re;
   sample_t push_im;
   idx_t    fill_cnt;
   logic    full;

   assign full = (fill_cnt == FILL_MAX);

   // -j rotation of the second operand in the odd half.
   always_comb begin
      if (tsel_i && sel_i) begin
         x_re = in_s.im;
         x_im = -in_s.re;
      end else begin
         x_re = in_s.re;
         x_im = in_s.im;
      end
   end

   always_comb begin
      if (sel_i) begin
         res_re  = dl_re[DLY-1] + x_re;
         res_im  = dl_im[DLY-1] + x_im;
         push_re = dl_re[DLY-1] - x_re;
         push_im = dl_im[DLY-1] - x_im;
      end else begin
         res_re  = dl_re[DLY-1];
         res_im  = dl_im[DLY-1];
         push_re = x_re;
         push_im = x_im;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         fill_cnt    <= '0;
         out_s.valid <= 1'b0;
         for (int i = 0; i < DLY; i++) begin
            dl_re[i] <= '0;
            dl_im[i] <= '0;
         end
      end else begin
         out_s.valid <= in_s.valid && full;
         if (in_s.valid) begin
            if (!full) begin
               fill_cnt <= fill_cnt + idx_t'(1);
            end
            for (int i = DLY - 1; i > 0; i--) begin
               dl_re[i] <= dl_re[i-1];
               dl_im[i] <= dl_im[i-1];
            end
            dl_re[0] <= push_re;
            dl_im[0] <= push_im;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_s.valid) begin
         out_s.re  <= res_re;
         out_s.im  <= res_im;
         out_s.ctr <= in_s.ctr - FILL_MAX;
      end
   end

endmodule

`default_nettype wire

//--- fft_stage/fft_bf.sv
`timescale 1ns/1ps
`default_nettype none

module fft_bf
   import fft_pkg::*;
#(
   parameter int STAGE = 0
) (
   input  logic      clk,
   input  logic      reset_i,
   fft_stream_if.dst in_s,
   fft_stream_if.src out_s
);

   localparam int SEL1_BIT = FFT_LOG2N - 1 - 2 * STAGE;
   localparam int SEL2_BIT = FFT_LOG2N - 2 - 2 * STAGE;

   logic sel1;
   logic sel2;
   logic tsel;

   fft_stream_if mid ();   // bf-i results in output order.

   assign sel1 = in_s.ctr[SEL1_BIT];
   assign sel2 = mid.ctr[SEL2_BIT];
   assign tsel = mid.ctr[SEL1_BIT];   // difference half of bf-i.

   fft_bfi #(
      .STAGE (STAGE)
   ) bfi (
      .clk     (clk),
      .reset_i (reset_i),
      .sel_i   (sel1),
      .in_s    (in_s),
      .out_s   (mid)
   );

   fft_bfii #(
      .STAGE (STAGE)
   ) bfii (
      .clk     (clk),
      .reset_i (reset_i),
      .sel_i   (sel2),
      .tsel_i  (tsel),
      .in_s    (mid),
      .out_s   (out_s)
   );

endmodule

`default_nettype wire

//--- design/fft_twiddle.sv
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle
   import fft_pkg::*;
(
   input  logic      clk,
   input  logic      reset_i,
   fft_stream_if.dst in_s,
   fft_stream_if.src out_s
);

   localparam int PROD_W = SAMPLE_W + TW_W + 1;

   typedef logic signed [PROD_W-1:0] prod_t;

   localparam prod_t HALF_LSB = prod_t'(1) <<< (TW_FRAC - 1);

   logic [1:0] grp;
   idx_t       exp_idx;
   twiddle_t   w_re;
   twiddle_t   w_im;
   logic       p_valid;
   idx_t       p_ctr;
   prod_t      p_re;
   prod_t      p_im;
   prod_t      r_re;
   prod_t      r_im;

   // k1 + 2*k2 of stage 0, times n3.
   assign grp     = {in_s.ctr[FFT_LOG2N-2], in_s.ctr[FFT_LOG2N-1]};
   assign exp_idx = idx_t'(grp) * idx_t'(in_s.ctr[1:0]);
   assign w_re    = TW_RE[exp_idx];
   assign w_im    = TW_IM[exp_idx];

   assign r_re = (p_re + HALF_LSB) >>> TW_FRAC;   // round half up.
   assign r_im = (p_im + HALF_LSB) >>> TW_FRAC;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         p_valid     <= 1'b0;
         out_s.valid <= 1'b0;
      end else begin
         p_valid     <= in_s.valid;
         out_s.valid <= p_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_s.valid) begin
         p_re  <= prod_t'(in_s.re) * prod_t'(w_re) - prod_t'(in_s.im) * prod_t'(w_im);
         p_im  <= prod_t'(in_s.re) * prod_t'(w_im) + prod_t'(in_s.im) * prod_t'(w_re);
         p_ctr <= in_s.ctr;
      end
      if (p_valid) begin
         out_s.re  <= r_re[SAMPLE_W-1:0];
         out_s.im  <= r_im[SAMPLE_W-1:0];
         out_s.ctr <= p_ctr;
      end
   end

   // first quarter of a frame passes through unrotated.
   assert property (@(posedge clk) disable iff (reset_i)
      (in_s.valid && (in_s.ctr[FFT_LOG2N-1 -: 2] == 2'b00))
      |-> ##2 (out_s.valid && (out_s.re == $past(in_s.re, 2))
               && (out_s.im == $past(in_s.im, 2))))
      else $error("twiddle exponent not zero in first quarter");

endmodule

`default_nettype wire

//--- design/fft_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fft_ctrl
   import fft_pkg::*;
(
   input  logic      clk,
   input  logic      reset_i,
   input  logic      valid_i,
   input  sample_t   re_i,
   input  sample_t   im_i,
   fft_stream_if.src in_s,
   fft_stream_if.dst out_s,
   output logic      valid_o,
   output sample_t   re_o,
   output sample_t   im_o,
   output idx_t      idx_o,
   output logic      frame_start_o
);

   idx_t in_cnt;
   idx_t out_cnt;

   assign in_s.valid = valid_i;
   assign in_s.re    = re_i;
   assign in_s.im    = im_i;
   assign in_s.ctr   = in_cnt;   // stamp input position.

   always_ff @(posedge clk) begin
      if (reset_i) begin
         in_cnt  <= '0;
         out_cnt <= '0;
      end else begin
         if (valid_i) begin
            in_cnt <= in_cnt + idx_t'(1);
         end
         if (out_s.valid) begin
            out_cnt <= out_cnt + idx_t'(1);
         end
      end
   end

   assign valid_o       = out_s.valid;
   assign re_o          = out_s.re;
   assign im_o          = out_s.im;
   assign frame_start_o = out_s.valid && (out_cnt == '0);

   // results leave in bit-reversed frequency order.
   always_comb begin
      for (int i = 0; i < FFT_LOG2N; i++) begin
         idx_o[i] = out_cnt[FFT_LOG2N-1-i];
      end
   end

   // counter re-timed through both stages must track the output count.
   assert property (@(posedge clk) disable iff (reset_i)
      out_s.valid |-> (out_s.ctr == out_cnt))
      else $error("stage counter out of step with output count");

endmodule

`default_nettype wire

//--- design/fft_r22sdf.sv
`timescale 1ns/1ps
`default_nettype none

module fft_r22sdf
   import fft_pkg::*;
(
   input  logic    clk,
   input  logic    reset_i,
   input  logic    valid_i,
   input  sample_t re_i,
   input  sample_t im_i,
   output logic    valid_o,
   output sample_t re_o,
   output sample_t im_o,
   output idx_t    idx_o,
   output logic    frame_start_o
);

   fft_stream_if s0 ();
   fft_stream_if s1 ();
   fft_stream_if s2 ();   // twiddled.
   fft_stream_if s3 ();

   fft_ctrl ctrl (
      .clk           (clk),
      .reset_i       (reset_i),
      .valid_i       (valid_i),
      .re_i          (re_i),
      .im_i          (im_i),
      .in_s          (s0),
      .out_s         (s3),
      .valid_o       (valid_o),
      .re_o          (re_o),
      .im_o          (im_o),
      .idx_o         (idx_o),
      .frame_start_o (frame_start_o)
   );

   fft_bf #(
      .STAGE (0)
   ) bf0 (
      .clk     (clk),
      .reset_i (reset_i),
      .in_s    (s0),
      .out_s   (s1)
   );

   fft_twiddle tw (
      .clk     (clk),
      .reset_i (reset_i),
      .in_s    (s1),
      .out_s   (s2)
   );

   fft_bf #(
      .STAGE (1)
   ) bf1 (
      .clk     (clk),
      .reset_i (reset_i),
      .in_s    (s2),
      .out_s   (s3)
   );

endmodule

`default_nettype wire

//--- verification/fft_model.svh
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH
`default_nettype none

// reverses the low index bits.
function automatic int bit_reverse(input int v);
   int r;
   r = 0;
   for (int i = 0; i < FFT_LOG2N; i++) begin
      r = r | (((v >> i) & 1) << (FFT_LOG2N - 1 - i));
   end
   return r;
endfunction

// multiply by w16^e with q1.14 coefficients, round half up.
function automatic void rotate_twiddle(input int xr, input int xi, input int e,
                                       output int yr, output int yi);
   int p_re;
   int p_im;
   p_re = xr * int'(TW_RE[e]) - xi * int'(TW_IM[e]);
   p_im = xr * int'(TW_IM[e]) + xi * int'(TW_RE[e]);
   yr   = (p_re + (1 << (TW_FRAC - 1))) >>> TW_FRAC;
   yi   = (p_im + (1 << (TW_FRAC - 1))) >>> TW_FRAC;
endfunction

// one output of a radix-2^2 butterfly over four points at equal stride.
function automatic void radix22_term(input int er [4], input int ei [4], input int k_lo,
                                     input int k_hi, output int yr, output int yi);
   int ar;
   int ai;
   int br;
   int bi;
   int tmp;
   ar = (k_lo != 0) ? er[0] - er[2] : er[0] + er[2];
   ai = (k_lo != 0) ? ei[0] - ei[2] : ei[0] + ei[2];
   br = (k_lo != 0) ? er[1] - er[3] : er[1] + er[3];
   bi = (k_lo != 0) ? ei[1] - ei[3] : ei[1] + ei[3];
   if (k_lo != 0) begin
      tmp = br;   // times -j.
      br  = bi;
      bi  = -tmp;
   end
   yr = (k_hi != 0) ? ar - br : ar + br;
   yi = (k_hi != 0) ? ai - bi : ai + bi;
endfunction

// 16-point dif transform, natural frequency order out.
function automatic void fft_model(input int xr [FFT_N], input int xi [FFT_N],
                                  output int yr [FFT_N], output int yi [FFT_N]);
   int er [4];
   int ei [4];
   int vr [FFT_N];
   int vi [FFT_N];
   int tr;
   int ti;
   int ur;
   int ui;
   // n = n3 + 4*m, partial frequency k12 = k1 + 2*k2.
   for (int n3 = 0; n3 < 4; n3++) begin
      for (int k12 = 0; k12 < 4; k12++) begin
         for (int m = 0; m < 4; m++) begin
            er[m] = xr[n3 + 4 * m];
            ei[m] = xi[n3 + 4 * m];
         end
         radix22_term(er, ei, k12 & 1, k12 >> 1, tr, ti);
         rotate_twiddle(tr, ti, (n3 * k12) % FFT_N, ur, ui);
         vr[4 * k12 + n3] = ur;
         vi[4 * k12 + n3] = ui;
      end
   end
   // four-point dft per k12, k = k12 + 4*k3.
   for (int k12 = 0; k12 < 4; k12++) begin
      for (int k3 = 0; k3 < 4; k3++) begin
         for (int m = 0; m < 4; m++) begin
            er[m] = vr[4 * k12 + m];
            ei[m] = vi[4 * k12 + m];
         end
         radix22_term(er, ei, k3 & 1, k3 >> 1, tr, ti);
         yr[k12 + 4 * k3] = tr;
         yi[k12 + 4 * k3] = ti;
      end
   end
endfunction

`default_nettype wire
`endif

//--- verification/fft_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft_tb
   import fft_pkg::*;
();

   localparam int NUM_RAND     = 20;
   localparam int TOTAL_FRAMES = 3 + 2 * NUM_RAND + 3;
   localparam int MAX_CYCLES   = (TOTAL_FRAMES + 2) * FFT_N * 4;

   logic    clk;
   logic    reset_i;
   logic    valid_i;
   sample_t re_i;
   sample_t im_i;
   logic    valid_o;
   sample_t re_o;
   sample_t im_o;
   idx_t    idx_o;
   logic    frame_start_o;

   int      seed;
   int      cycle_cnt;
   int      checks;
   int      errors;
   int      test_errs;
   int      tests_run;
   int      tests_failed;
   int      outs;
   int      starts;
   int      rnd_re [NUM_RAND*FFT_N];
   int      rnd_im [NUM_RAND*FFT_N];
   sample_t exp_re [$];
   sample_t exp_im [$];
   idx_t    exp_idx [$];
   logic    exp_start [$];

   fft_r22sdf dut0 (
      .clk           (clk),
      .reset_i       (reset_i),
      .valid_i       (valid_i),
      .re_i          (re_i),
      .im_i          (im_i),
      .valid_o       (valid_o),
      .re_o          (re_o),
      .im_o          (im_o),
      .idx_o         (idx_o),
      .frame_start_o (frame_start_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, results still missing", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic note_error();
      errors++;
      test_errs++;
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t want);
      checks++;
      if (got !== want) begin
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
         note_error();
      end
   endtask

   task automatic check_idx(input string name, input idx_t got, input idx_t want);
      checks++;
      if (got !== want) begin
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
         note_error();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, want);
         note_error();
      end
   endtask

   // outputs are registered, so they are steady at the falling edge.
   always @(negedge clk) begin
      if (!reset_i && valid_o !== 1'b0) begin
         if (valid_o !== 1'b1) begin
            $display("valid_o is unknown at %0t", $time);
            note_error();
         end else if (exp_re.size() == 0) begin
            $display("valid_o high at %0t with no result pending", $time);
            note_error();
         end else begin
            check_sample("re_o", re_o, exp_re.pop_front());
            check_sample("im_o", im_o, exp_im.pop_front());
            check_idx("idx_o", idx_o, exp_idx.pop_front());
            check_flag("frame_start_o", frame_start_o, exp_start.pop_front());
            outs++;
            if (frame_start_o) begin
               starts++;
            end
         end
      end
   end

   task automatic drive(input logic v, input int re, input int im);
      @(negedge clk);
      valid_i = v;
      re_i    = sample_t'(re);
      im_i    = sample_t'(im);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset_i = 1'b1;
      valid_i = 1'b0;
      repeat (5) @(negedge clk);
      reset_i = 1'b0;
   endtask

   task automatic send_frame(input int fr [FFT_N], input int fi [FFT_N], input bit gaps);
      int yr [FFT_N];
      int yi [FFT_N];
      int k;
      for (int n = 0; n < FFT_N; n++) begin
         while (gaps && (($random(seed) & 3) == 0)) begin
            drive(1'b0, 0, 0);
         end
         drive(1'b1, fr[n], fi[n]);
      end
      fft_model(fr, fi, yr, yi);
      for (int q = 0; q < FFT_N; q++) begin
         k = bit_reverse(q);   // bit-reversed output order.
         exp_re.push_back(sample_t'(yr[k]));
         exp_im.push_back(sample_t'(yi[k]));
         exp_idx.push_back(idx_t'(k));
         exp_start.push_back(q == 0);
      end
   endtask

   task automatic start_test();
      test_errs = 0;
      outs      = 0;
      starts    = 0;
      apply_reset();
      check_flag("valid_o", valid_o, 1'b0);
   endtask

   task automatic end_test(input string name, input int frames);
      repeat (FFT_N - 1) drive(1'b1, 0, 0);   // zero samples drain last frame.
      drive(1'b0, 0, 0);
      while (exp_re.size() != 0) begin
         @(negedge clk);
      end
      repeat (8) @(negedge clk);
      if (outs != frames * FFT_N) begin
         $display("%s: saw %0d outputs instead of %0d", name, outs, frames * FFT_N);
         note_error();
      end
      if (starts * FFT_N != outs) begin
         $display("%s: frame_start_o seen %0d times for %0d outputs", name, starts, outs);
         note_error();
      end
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s: pass, %0d outputs", name, outs);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d errors", name, test_errs);
      end
   endtask

   initial begin
      int fr [FFT_N];
      int fi [FFT_N];
      int e;
      reset_i      = 1'b1;
      valid_i      = 1'b0;
      re_i         = '0;
      im_i         = '0;
      seed         = 32'h1f8d;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < NUM_RAND * FFT_N; i++) begin
         rnd_re[i] = $random(seed) % 512;
         rnd_im[i] = $random(seed) % 512;
      end

      start_test();
      for (int n = 0; n < FFT_N; n++) begin
         fr[n] = (n == 0) ? 100 : 0;
         fi[n] = 0;
      end
      send_frame(fr, fi, 1'b0);
      end_test("impulse", 1);

      start_test();
      for (int n = 0; n < FFT_N; n++) begin
         fr[n] = 50;
         fi[n] = 0;
      end
      send_frame(fr, fi, 1'b0);
      end_test("constant", 1);

      start_test();
      for (int n = 0; n < FFT_N; n++) begin
         e     = (3 * n) % FFT_N;   // bin 3.
         fr[n] = (400 * int'(TW_RE[e]) + 8192) >>> TW_FRAC;
         fi[n] = (-400 * int'(TW_IM[e]) + 8192) >>> TW_FRAC;
      end
      send_frame(fr, fi, 1'b0);
      end_test("tone", 1);

      for (int pass = 0; pass < 2; pass++) begin
         start_test();
         for (int f = 0; f < NUM_RAND; f++) begin
            for (int n = 0; n < FFT_N; n++) begin
               fr[n] = rnd_re[f * FFT_N + n];
               fi[n] = rnd_im[f * FFT_N + n];
            end
            send_frame(fr, fi, pass == 1);
         end
         end_test((pass == 1) ? "gaps" : "random", NUM_RAND);
      end

      // reset in mid frame, then nothing may come out until a full frame.
      start_test();
      repeat (FFT_N / 2) drive(1'b1, 300, -300);
      apply_reset();
      repeat (2 * FFT_N) drive(1'b0, 0, 0);
      for (int f = 0; f < 3; f++) begin
         for (int n = 0; n < FFT_N; n++) begin
            fr[n] = rnd_re[f * FFT_N + n];
            fi[n] = rnd_im[f * FFT_N + n];
         end
         send_frame(fr, fi, 1'b0);
      end
      end_test("reset", 3);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

`include "fft_model.svh"

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
common/fft_pkg.sv
common/fft_stream_if.sv
fft_stage/fft_bfi.sv
fft_stage/fft_bfii.sv
fft_stage/fft_bf.sv
design/fft_twiddle.sv
design/fft_ctrl.sv
design/fft_r22sdf.sv
verification/fft_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FFT testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module fft_tb -Mdir obj_dir -o fft_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/fft_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1
